// File: Makefile
TOP := cpu_tb

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: bench/cpu_checker.sv
module cpu_checker import rv_pkg::*; (
    input logic      clk_i,
    input logic      rst_n_i,
    input logic      wb_valid_i,
    input reg_addr_t wb_rd_i,
    input xlen_t     imem_addr_i
);

    // the first reset edge has already cleared the valid bits
    wb_quiet_in_reset: assert property (
        @(negedge clk_i) !rst_n_i |-> !wb_valid_i
    ) else $error("writeback valid while reset is held");

    wb_rd_nonzero: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) wb_valid_i |-> wb_rd_i != '0
    ) else $error("writeback to x0 reported as valid");

    fetch_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) imem_addr_i[1:0] == 2'b00
    ) else $error("fetch address %h is not word aligned", imem_addr_i);

endmodule

bind cpu_top cpu_checker checker0 (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wb_valid_i (wb_valid_o),
    .wb_rd_i    (wb_rd_o),
    .imem_addr_i(imem_addr_o)
);

// File: bench/cpu_tb.sv
module cpu_tb import rv_pkg::*; ();

    typedef struct packed {
        xlen_t     pc;
        reg_addr_t rd;
        xlen_t     data;
    } retire_t;

    logic        clk;
    logic        rst_n;
    xlen_t       imem_addr;
    xlen_t       imem_inst = 32'h0000007f;
    logic        wb_valid;
    reg_addr_t   wb_rd;
    xlen_t       wb_data;
    xlen_t       wb_pc;
    xlen_t       prog [$];
    xlen_t       imem [];
    retire_t     expected [$];
    logic [31:0] rng_state;
    int          timeout_cycles;

    tb_clock #(.PERIOD(4), .RESET_CYCLES(8)) clock_gen (.clk_o(clk), .rst_n_o(rst_n));

    cpu_top #(.RESET_PC(32'h0)) dut0 (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .imem_addr_o(imem_addr),
        .imem_inst_i(imem_inst),
        .wb_valid_o (wb_valid),
        .wb_rd_o    (wb_rd),
        .wb_data_o  (wb_data),
        .wb_pc_o    (wb_pc)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // picks one of x1..x15 and never x0
    function automatic reg_addr_t pick_reg(logic [3:0] n);
        return (n == 4'd0) ? 5'd1 : {1'b0, n};
    endfunction

    function automatic xlen_t r_type(logic [2:0] f3, logic alt, reg_addr_t rd,
                                     reg_addr_t rs1, reg_addr_t rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic xlen_t i_type(logic [6:0] opc, logic [2:0] f3, reg_addr_t rd,
                                     reg_addr_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic xlen_t u_type(logic [6:0] opc, reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic xlen_t b_type(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
                                     logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic xlen_t j_type(reg_addr_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // addi rd, rd, 1
    task automatic push_step(reg_addr_t rd);
        prog.push_back(i_type(7'b0010011, 3'b000, rd, rd, 12'd1));
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] r2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        // x28..x30 count the steps around the branches
        for (int k = 28; k <= 30; k++) begin
            r = next_random();
            prog.push_back(i_type(7'b0010011, 3'b000, 5'(k), 5'd0, r[11:0]));
        end
        // x1..x3 get random values and x3 is negative
        for (int k = 1; k <= 3; k++) begin
            r  = next_random();
            r2 = next_random();
            if (k == 3) begin
                r[31] = 1'b1;
            end
            prog.push_back(u_type(7'b0110111, 5'(k), r[31:12]));
            prog.push_back(i_type(7'b0010011, 3'b000, 5'(k), 5'(k), r2[11:0]));
        end
        for (int k = 0; k < 8; k++) begin
            prog.push_back(r_type(3'(k), 1'b0, 5'(4 + k), 5'd1, 5'd3));
        end
        prog.push_back(r_type(3'b000, 1'b1, 5'd12, 5'd2, 5'd3));
        prog.push_back(r_type(3'b101, 1'b1, 5'd13, 5'd3, 5'd2));
        for (int k = 0; k < 8; k++) begin
            r   = next_random();
            imm = (k == 1 || k == 5) ? {7'b0, r[4:0]} : r[11:0];
            prog.push_back(i_type(7'b0010011, 3'(k), 5'(14 + k), 5'd3, imm));
        end
        r = next_random();
        prog.push_back(i_type(7'b0010011, 3'b101, 5'd22, 5'd3, {7'b0100000, r[4:0]}));
        // random mix often at forwarding distance
        for (int k = 0; k < 16; k++) begin
            r   = next_random();
            f3  = r[14:12];
            alt = r[15] && (f3 == 3'b101 || (r[16] && f3 == 3'b000));
            if (r[16]) begin
                prog.push_back(r_type(f3, alt, pick_reg(r[3:0]), pick_reg(r[7:4]),
                                      pick_reg(r[11:8])));
            end else begin
                imm = (f3 == 3'b001 || f3 == 3'b101) ? {1'b0, alt, 5'b0, r[24:20]} : r[31:20];
                prog.push_back(i_type(7'b0010011, f3, pick_reg(r[3:0]), pick_reg(r[7:4]), imm));
            end
        end
        prog.push_back(r_type(3'b000, 1'b0, 5'd23, 5'd1, 5'd2));
        prog.push_back(r_type(3'b000, 1'b0, 5'd24, 5'd23, 5'd23));
        prog.push_back(r_type(3'b000, 1'b1, 5'd25, 5'd23, 5'd24));
        prog.push_back(r_type(3'b100, 1'b0, 5'd26, 5'd25, 5'd23));
        r = next_random();
        prog.push_back(u_type(7'b0010111, 5'd27, r[19:0]));
        // every branch hops over two steps to a third
        for (int p = 0; p < 3; p++) begin
            rs1 = (p == 2) ? 5'd3 : 5'd1;
            rs2 = (p == 0) ? 5'd1 : ((p == 1) ? 5'd3 : 5'd2);
            for (int k = 0; k < 6; k++) begin
                f3 = (k < 2) ? 3'(k) : 3'(k + 2);
                prog.push_back(b_type(f3, rs1, rs2, 13'd12));
                push_step(5'd28);
                push_step(5'd29);
                push_step(5'd30);
            end
        end
        prog.push_back(j_type(5'd31, 21'd12));
        push_step(5'd28);
        push_step(5'd29);
        prog.push_back(j_type(5'd0, 21'd12));
        push_step(5'd28);
        push_step(5'd29);
        // odd jalr offsets land on the word after the next
        prog.push_back(u_type(7'b0010111, 5'd5, 20'd0));
        prog.push_back(i_type(7'b1100111, 3'b000, 5'd6, 5'd5, 12'd13));
        push_step(5'd28);
        prog.push_back(u_type(7'b0010111, 5'd7, 20'd0));
        prog.push_back(i_type(7'b1100111, 3'b000, 5'd7, 5'd7, 12'd13));
        push_step(5'd28);
        push_step(5'd30);
        prog.push_back(i_type(7'b0010011, 3'b000, 5'd0, 5'd1, 12'd5));
        prog.push_back(r_type(3'b000, 1'b0, 5'd9, 5'd0, 5'd1));
        // lw and fence are unknown to this core
        prog.push_back(32'h0000a083);
        prog.push_back(32'h0000000f);
        prog.push_back(r_type(3'b110, 1'b0, 5'd10, 5'd1, 5'd0));
    endtask

    function automatic xlen_t golden_alu(logic [2:0] f3, logic alt, xlen_t a, xlen_t b);
        xlen_t r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic golden_taken(logic [2:0] f3, xlen_t a, xlen_t b);
        logic t;
        case (f3)
            3'b000:  t = a == b;
            3'b001:  t = a != b;
            3'b100:  t = $signed(a) < $signed(b);
            3'b101:  t = $signed(a) >= $signed(b);
            3'b110:  t = a < b;
            3'b111:  t = a >= b;
            default: t = 1'b0;
        endcase
        return t;
    endfunction

    task automatic run_golden_model();
        xlen_t     gpr [0:31];
        xlen_t     pc;
        xlen_t     inst;
        xlen_t     next_pc;
        xlen_t     res;
        xlen_t     a;
        xlen_t     imm_i;
        logic      wr;
        reg_addr_t rd;
        retire_t   item;
        int        steps;
        for (int i = 0; i < 32; i++) begin
            gpr[i] = '0;
        end
        pc    = '0;
        steps = 0;
        while ({2'b00, pc[31:2]} < 32'(prog.size()) && steps < 1000) begin
            inst    = prog[pc[31:2]];
            rd      = inst[11:7];
            a       = gpr[inst[19:15]];
            imm_i   = {{20{inst[31]}}, inst[31:20]};
            next_pc = pc + 32'd4;
            wr      = 1'b1;
            res     = pc + 32'd4;
            case (inst[6:0])
                7'b0110011: res = golden_alu(inst[14:12], inst[30], a, gpr[inst[24:20]]);
                7'b0010011: res = golden_alu(inst[14:12], inst[30] && inst[14:12] == 3'b101,
                                             a, imm_i);
                7'b0110111: res = {inst[31:12], 12'b0};
                7'b0010111: res = pc + {inst[31:12], 12'b0};
                7'b1101111: next_pc = pc + {{12{inst[31]}}, inst[19:12], inst[20],
                                            inst[30:21], 1'b0};
                7'b1100111: next_pc = (a + imm_i) & ~32'd1;
                7'b1100011: begin
                    wr = 1'b0;
                    if (golden_taken(inst[14:12], a, gpr[inst[24:20]])) begin
                        next_pc = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && rd != 5'd0) begin
                gpr[rd]   = res;
                item.pc   = pc;
                item.rd   = rd;
                item.data = res;
                expected.push_back(item);
            end
            pc = next_pc;
            steps++;
        end
    endtask

    function automatic xlen_t fetch_word(xlen_t addr);
        logic [31:0] idx;
        xlen_t       w;
        idx = {2'b00, addr[31:2]};
        if (idx < 32'(imem.size())) begin
            w = imem[idx];
        end else begin
            // past the program the word has an unknown opcode
            w = {addr[31:7] ^ {18'b0, addr[6:0]}, 7'b1111111};
        end
        return w;
    endfunction

    task automatic stop_with_failure(string reason);
        $display("test failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_word(string what, xlen_t got, xlen_t want);
        if (got !== want) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, want);
            stop_with_failure("retirement mismatch");
        end
    endtask

    task automatic check_reg(string what, reg_addr_t got, reg_addr_t want);
        if (got !== want) begin
            $display("Fail at %0t: %s is x%0d, expected x%0d", $time, what, got, want);
            stop_with_failure("retirement mismatch");
        end
    endtask

    always @(negedge clk) begin
        imem_inst <= fetch_word(imem_addr);
    end

    always @(negedge clk) begin
        retire_t want;
        if (rst_n && wb_valid) begin
            if (expected.size() == 0) begin
                $display("an instruction at pc %h retired after the last expected one", wb_pc);
                stop_with_failure("unexpected retirement");
            end else begin
                want = expected.pop_front();
                check_word("pc", wb_pc, want.pc);
                check_reg("rd", wb_rd, want.rd);
                check_word("data", wb_data, want.data);
            end
        end
    end

    initial begin
        @(posedge rst_n);
        repeat (timeout_cycles) @(negedge clk);
        $display("timeout, %0d retirements never arrived", expected.size());
        stop_with_failure("watchdog expired");
    end

    initial begin
        rng_state = 32'he566;
        build_program();
        imem = new[prog.size()];
        for (int i = 0; i < prog.size(); i++) begin
            imem[i] = prog[i];
        end
        run_golden_model();
        timeout_cycles = 8 * prog.size() + 100;
        @(posedge rst_n);
        while (expected.size() != 0) begin
            @(posedge clk);
        end
        // nothing may retire after the last one
        repeat (20) @(posedge clk);
        $display("test passed");
        $finish;
    end

endmodule

// File: bench/tb_clock.sv
module tb_clock #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // release on a falling edge, like every other input
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// File: hdl/cpu_top.sv
module cpu_top import rv_pkg::*; #(
    parameter xlen_t RESET_PC = '0
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    output xlen_t     imem_addr_o,
    input  xlen_t     imem_inst_i,
    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output xlen_t     wb_data_o,
    output xlen_t     wb_pc_o
);

    logic      redirect;
    xlen_t     redirect_pc;
    logic      id_valid;
    xlen_t     id_pc;
    xlen_t     id_inst;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    logic      id_ex_valid_d;
    id_ex_t    id_ex_d;
    logic      ex_valid;
    id_ex_t    ex_payload;
    logic      ex_wb_valid_d;
    ex_wb_t    ex_wb_d;
    logic      wb_valid;
    ex_wb_t    wb_payload;

    fwd_if fwd_bus ();

    fetch_stage #(.RESET_PC(RESET_PC)) fetch_stage_instance (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .redirect_i   (redirect),
        .redirect_pc_i(redirect_pc),
        .imem_addr_o  (imem_addr_o),
        .imem_inst_i  (imem_inst_i),
        .id_valid_o   (id_valid),
        .id_pc_o      (id_pc),
        .id_inst_o    (id_inst)
    );

    decode_stage decode_stage_instance (
        .valid_i   (id_valid),
        .pc_i      (id_pc),
        .inst_i    (id_inst),
        .rs1_addr_o(rs1_addr),
        .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .fwd       (fwd_bus.sink),
        .ex_valid_o(id_ex_valid_d),
        .ex_o      (id_ex_d)
    );

    regfile regfile_instance (
        .clk_i     (clk_i),
        .rs1_addr_i(rs1_addr),
        .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data),
        .we_i      (wb_valid),
        .wr_addr_i (wb_payload.rd),
        .wr_data_i (wb_payload.data)
    );

    // a taken branch or jump squashes the instruction in decode
    pipe_reg #(.T(id_ex_t)) id_ex_instance (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .flush_i(redirect),
        .valid_i(id_ex_valid_d),
        .data_i (id_ex_d),
        .valid_o(ex_valid),
        .data_o (ex_payload)
    );

    execute_stage execute_stage_instance (
        .valid_i      (ex_valid),
        .ex_i         (ex_payload),
        .fwd          (fwd_bus.ex_src),
        .redirect_o   (redirect),
        .redirect_pc_o(redirect_pc),
        .wb_valid_o   (ex_wb_valid_d),
        .wb_o         (ex_wb_d)
    );

    pipe_reg #(.T(ex_wb_t)) ex_wb_instance (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .flush_i(1'b0),
        .valid_i(ex_wb_valid_d),
        .data_i (ex_wb_d),
        .valid_o(wb_valid),
        .data_o (wb_payload)
    );

    assign fwd_bus.wb_valid = wb_valid;
    assign fwd_bus.wb_rd    = wb_payload.rd;
    assign fwd_bus.wb_data  = wb_payload.data;

    assign wb_valid_o = wb_valid;
    assign wb_rd_o    = wb_payload.rd;
    assign wb_data_o  = wb_payload.data;
    assign wb_pc_o    = wb_payload.pc;

endmodule

// File: hdl/decode_stage.sv
module decode_stage import rv_pkg::*; (
    input  logic      valid_i,
    input  xlen_t     pc_i,
    input  xlen_t     inst_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    input  xlen_t     rs1_data_i,
    input  xlen_t     rs2_data_i,
    fwd_if.sink       fwd,
    output logic      ex_valid_o,
    output id_ex_t    ex_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      imm_b;
    xlen_t      imm_j;

    // alt selects sub for 000 and sra/srai for 101
    function automatic alu_op_e alu_from_funct3(logic [2:0] f3, logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // execute result is younger than writeback, so it wins
    function automatic xlen_t operand(reg_addr_t addr, xlen_t rf_data);
        xlen_t val;
        val = rf_data;
        if (addr != '0 && fwd.ex_valid && fwd.ex_rd == addr) begin
            val = fwd.ex_data;
        end else if (addr != '0 && fwd.wb_valid && fwd.wb_rd == addr) begin
            val = fwd.wb_data;
        end
        return val;
    endfunction

    assign opcode    = inst_i[6:0];
    assign funct3    = inst_i[14:12];
    assign funct7_b5 = inst_i[30];

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    assign ex_valid_o = valid_i;

    always_comb begin
        ex_o           = '0;
        ex_o.pc        = pc_i;
        ex_o.rs1_val   = operand(rs1_addr_o, rs1_data_i);
        ex_o.rs2_val   = operand(rs2_addr_o, rs2_data_i);
        ex_o.rd        = inst_i[11:7];
        ex_o.alu_op    = ALU_ADD;
        ex_o.br_op     = BR_NONE;
        case (opcode)
            OPC_OP: begin
                ex_o.alu_op    = alu_from_funct3(funct3, funct7_b5);
                ex_o.writes_rd = 1'b1;
            end
            OPC_OP_IMM: begin
                // only srai looks at bit 30
                ex_o.alu_op    = alu_from_funct3(funct3, funct7_b5 && funct3 == 3'b101);
                ex_o.imm       = imm_i;
                ex_o.use_imm   = 1'b1;
                ex_o.writes_rd = 1'b1;
            end
            OPC_LUI: begin
                ex_o.alu_op    = ALU_PASS_B;
                ex_o.imm       = imm_u;
                ex_o.use_imm   = 1'b1;
                ex_o.writes_rd = 1'b1;
            end
            OPC_AUIPC: begin
                ex_o.imm       = imm_u;
                ex_o.use_imm   = 1'b1;
                ex_o.use_pc    = 1'b1;
                ex_o.writes_rd = 1'b1;
            end
            OPC_JAL: begin
                ex_o.imm       = imm_j;
                ex_o.is_jal    = 1'b1;
                ex_o.writes_rd = 1'b1;
            end
            OPC_JALR: begin
                ex_o.imm       = imm_i;
                ex_o.is_jalr   = 1'b1;
                ex_o.writes_rd = 1'b1;
            end
            OPC_BRANCH: begin
                ex_o.imm = imm_b;
                case (funct3)
                    3'b000:  ex_o.br_op = BR_EQ;
                    3'b001:  ex_o.br_op = BR_NE;
                    3'b100:  ex_o.br_op = BR_LT;
                    3'b101:  ex_o.br_op = BR_GE;
                    3'b110:  ex_o.br_op = BR_LTU;
                    3'b111:  ex_o.br_op = BR_GEU;
                    default: ex_o.br_op = BR_NONE;
                endcase
            end
            // anything else travels on as a bubble
            default: ;
        endcase
    end

endmodule

// File: hdl/execute_stage.sv
module execute_stage import rv_pkg::*; (
    input  logic   valid_i,
    input  id_ex_t ex_i,
    fwd_if.ex_src  fwd,
    output logic   redirect_o,
    output xlen_t  redirect_pc_o,
    output logic   wb_valid_o,
    output ex_wb_t wb_o
);

    xlen_t      op_a;
    xlen_t      op_b;
    logic [4:0] shamt;
    xlen_t      alu_res;
    xlen_t      result;
    xlen_t      jalr_sum;
    logic       is_jump;
    logic       taken;

    assign op_a  = ex_i.use_pc ? ex_i.pc : ex_i.rs1_val;
    assign op_b  = ex_i.use_imm ? ex_i.imm : ex_i.rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ex_i.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = xlen_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_res = xlen_t'(op_a < op_b);
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = xlen_t'($signed(op_a) >>> shamt);
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // comparator always works on the register operands
    always_comb begin
        case (ex_i.br_op)
            BR_EQ:   taken = ex_i.rs1_val == ex_i.rs2_val;
            BR_NE:   taken = ex_i.rs1_val != ex_i.rs2_val;
            BR_LT:   taken = $signed(ex_i.rs1_val) < $signed(ex_i.rs2_val);
            BR_GE:   taken = $signed(ex_i.rs1_val) >= $signed(ex_i.rs2_val);
            BR_LTU:  taken = ex_i.rs1_val < ex_i.rs2_val;
            BR_GEU:  taken = ex_i.rs1_val >= ex_i.rs2_val;
            default: taken = 1'b0;
        endcase
    end

    assign is_jump = ex_i.is_jal || ex_i.is_jalr;

    // link value for jal and jalr
    assign result = is_jump ? ex_i.pc + xlen_t'(4) : alu_res;

    assign jalr_sum      = ex_i.rs1_val + ex_i.imm;
    assign redirect_o    = valid_i && (taken || is_jump);
    assign redirect_pc_o = ex_i.is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : ex_i.pc + ex_i.imm;

    // x0 writes and branches never leave this stage as valid
    assign wb_valid_o = valid_i && ex_i.writes_rd && ex_i.rd != '0;
    assign wb_o.pc    = ex_i.pc;
    assign wb_o.rd    = ex_i.rd;
    assign wb_o.data  = result;

    assign fwd.ex_valid = wb_valid_o;
    assign fwd.ex_rd    = ex_i.rd;
    assign fwd.ex_data  = result;

endmodule

// File: hdl/fetch_stage.sv
module fetch_stage import rv_pkg::*; #(
    parameter xlen_t RESET_PC = '0
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  redirect_i,
    input  xlen_t redirect_pc_i,
    output xlen_t imem_addr_o,
    input  xlen_t imem_inst_i,
    output logic  id_valid_o,
    output xlen_t id_pc_o,
    output xlen_t id_inst_o
);

    typedef logic [2*XLEN-1:0] if_id_t;

    xlen_t  pc;
    xlen_t  pc_next;
    if_id_t if_id_q;

    assign pc_next = redirect_i ? redirect_pc_i : pc + xlen_t'(4);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // imem answers in the same cycle
    assign imem_addr_o = pc;

    // IF/ID register, the fetched word dies on a redirect
    pipe_reg #(.T(if_id_t)) if_id_instance (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .flush_i(redirect_i),
        .valid_i(1'b1),
        .data_i ({pc, imem_inst_i}),
        .valid_o(id_valid_o),
        .data_o (if_id_q)
    );

    assign id_pc_o   = if_id_q[2*XLEN-1:XLEN];
    assign id_inst_o = if_id_q[XLEN-1:0];

endmodule

// File: hdl/fwd_if.sv
interface fwd_if import rv_pkg::*; ();

    // result leaving the ALU this cycle
    logic      ex_valid;
    reg_addr_t ex_rd;
    xlen_t     ex_data;

    // result being written back this cycle
    logic      wb_valid;
    reg_addr_t wb_rd;
    xlen_t     wb_data;

    modport ex_src (output ex_valid, output ex_rd, output ex_data);

    modport wb_src (output wb_valid, output wb_rd, output wb_data);

    modport sink (
        input ex_valid, input ex_rd, input ex_data,
        input wb_valid, input wb_rd, input wb_data
    );

endinterface

// File: hdl/pipe_reg.sv
module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic flush_i,
    input  logic valid_i,
    input  T     data_i,
    output logic valid_o,
    output T     data_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // payload is only looked at while valid
    always_ff @(posedge clk_i) begin
        data_o <= data_i;
    end

endmodule

// File: hdl/regfile.sv
module regfile import rv_pkg::*; (
    input  logic      clk_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o,
    input  logic      we_i,
    input  reg_addr_t wr_addr_i,
    input  xlen_t     wr_data_i
);

    // x0 has no storage
    xlen_t regs [1:31];

    always_ff @(posedge clk_i) begin
        if (we_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // write in the same cycle is covered by writeback forwarding
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: hdl/rv_pkg.sv
package rv_pkg;

    parameter int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;

    // base opcodes kept by this core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        // lui result
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_op_e;

    // decode to execute
    typedef struct packed {
        xlen_t     pc;
        xlen_t     rs1_val;
        xlen_t     rs2_val;
        xlen_t     imm;
        reg_addr_t rd;
        alu_op_e   alu_op;
        br_op_e    br_op;
        logic      use_imm;
        logic      use_pc;
        logic      is_jal;
        logic      is_jalr;
        logic      writes_rd;
    } id_ex_t;

    // execute to writeback
    typedef struct packed {
        xlen_t     pc;
        reg_addr_t rd;
        xlen_t     data;
    } ex_wb_t;

endpackage

// File: tb.f
hdl/rv_pkg.sv
hdl/fwd_if.sv
hdl/pipe_reg.sv
hdl/regfile.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/cpu_top.sv
bench/tb_clock.sv
bench/cpu_checker.sv
bench/cpu_tb.sv
